//--- logic/i2c_pkg.sv
package i2c_pkg;

    // one byte as it travels on the two-wire bus
    typedef logic [7:0] byte_t;

    // 24Cxx device type code, upper nibble of the control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // counter width over the four quarters of a bit slot
    localparam int QUARTER_BITS = 2;

    typedef enum logic [1:0] {
        op_start,
        op_stop,
        op_write,
        op_read
    } bus_op_t;

    typedef enum logic [1:0] {
        ph_idle,
        ph_cond,  // start or stop
        ph_byte   // nine bit slots
    } bit_phase_t;

endpackage

//--- logic/mem_pkg.sv
package mem_pkg;

    typedef logic [10:0] addr_t;  // 2048 bytes
    typedef logic [2:0] block_t;  // A10..A8

    // sequencer states, one per bus operation plus idle and done
    typedef enum logic [3:0] {
        s_idle,
        s_start,
        s_ctrl_w,
        s_addr,
        s_data_w,
        s_restart,
        s_ctrl_r,
        s_data_r,
        s_stop,
        s_done
    } seq_state_t;

endpackage

//--- logic/bus_op_if.sv
`timescale 1ns/1ps

interface bus_op_if;
    import i2c_pkg::*;

    bus_op_t op;
    logic    go;           // one-cycle request strobe
    byte_t   tx_byte;
    logic    master_nack;  // level sent in the ack slot of a read
    logic    done;         // one-cycle pulse, operation finished
    byte_t   rx_byte;
    logic    slave_nack;

    modport seq (output op, go, tx_byte, master_nack, input done, rx_byte, slave_nack);
    modport engine (input op, go, tx_byte, master_nack, output done, rx_byte, slave_nack);

endinterface

//--- logic/frame_if.sv
`timescale 1ns/1ps

interface frame_if;
    import i2c_pkg::*;

    logic  load;
    byte_t tx_byte;     // all ones for a read
    logic  ack_bit;
    logic  shift;
    logic  sda_sample;
    logic  rx_bit;      // line level to capture
    logic  out_bit;     // bit for the coming slot
    logic  last_slot;
    byte_t rx_byte;
    logic  ack_seen;

    modport engine (output load, tx_byte, ack_bit, shift, sda_sample, rx_bit,
                    input out_bit, last_slot, rx_byte, ack_seen);
    modport shifter (input load, tx_byte, ack_bit, shift, sda_sample, rx_bit,
                     output out_bit, last_slot, rx_byte, ack_seen);

endinterface

//--- logic/frame_shifter.sv
`timescale 1ns/1ps

module frame_shifter (
    input  logic      CLK,
    input  logic      RESET,
    frame_if.shifter  frm
);

    logic [8:0] sr;    // sr[8] is the bit on the wire
    logic [3:0] slot;

    // sampled bit replaces the sent one, then the register rotates,
    // so after eight rotations sr holds {ack, rx7..rx0}
    always_ff @(posedge CLK)
    begin
        if (frm.load)
            sr <= {frm.tx_byte, frm.ack_bit};
        else if (frm.sda_sample)
            sr[8] <= frm.rx_bit;
        else if (frm.shift)
            sr <= {sr[7:0], sr[8]};
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            slot <= '0;
        else if (frm.load)
            slot <= '0;
        else if (frm.shift)
            slot <= slot + 1'b1;
    end

    // next bit for the pad, valid with load or shift
    assign frm.out_bit = frm.load ? frm.tx_byte[7] : sr[7];
    assign frm.last_slot = (slot == 4'd8);
    assign frm.rx_byte = sr[7:0];
    assign frm.ack_seen = sr[8];  // ack slot level in the last slot

endmodule

//--- logic/bit_engine.sv
`timescale 1ns/1ps

module bit_engine (
    input  logic     CLK,
    input  logic     RESET,
    bus_op_if.engine bus,
    frame_if.engine  frm,
    output logic     scl,
    output logic     sda_drive_low,
    input  logic     sda_in
);
    import i2c_pkg::*;

    bit_phase_t              phase;
    logic [QUARTER_BITS-1:0] q;     // quarter within the current slot
    bus_op_t                 op_r;
    logic                    q_last;
    logic                    q_sample;
    logic                    byte_op;

    assign q_last = (q == '1);
    assign q_sample = (q == QUARTER_BITS'(2));
    assign byte_op = (bus.op == op_write) || (bus.op == op_read);

    // low in q0 and q1, high otherwise and while idle
    assign scl = (phase == ph_idle) || q[QUARTER_BITS-1];

    // read: data slots released, ack slot from the sequencer
    assign frm.load = bus.go && (phase == ph_idle) && byte_op;
    assign frm.tx_byte = (bus.op == op_read) ? '1 : bus.tx_byte;
    assign frm.ack_bit = (bus.op == op_read) ? bus.master_nack : 1'b1;
    assign frm.sda_sample = (phase == ph_byte) && q_sample;
    assign frm.shift = (phase == ph_byte) && q_last && !frm.last_slot;
    assign frm.rx_bit = sda_in;

    assign bus.done = q_last && ((phase == ph_cond) || ((phase == ph_byte) && frm.last_slot));
    assign bus.rx_byte = frm.rx_byte;
    assign bus.slave_nack = frm.ack_seen;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase <= ph_idle;
            q <= '0;
            op_r <= op_start;
            sda_drive_low <= 1'b0;
        end
        else if (phase == ph_idle)
        begin
            if (bus.go)
            begin
                op_r <= bus.op;
                q <= '0;
                case (bus.op)
                    op_start:
                    begin
                        phase <= ph_cond;
                        sda_drive_low <= 1'b0;  // released until q3
                    end
                    op_stop:
                    begin
                        phase <= ph_cond;
                        sda_drive_low <= 1'b1;  // low until q3
                    end
                    default:
                    begin
                        phase <= ph_byte;
                        sda_drive_low <= ~frm.out_bit;  // first data bit at q0
                    end
                endcase
            end
        end
        else
        begin
            q <= q + 1'b1;
            // SDA edge while SCL is high
            if ((phase == ph_cond) && q_sample)
                sda_drive_low <= (op_r == op_start);
            if (q_last)
            begin
                if ((phase == ph_cond) || frm.last_slot)
                    phase <= ph_idle;  // line held as is until next op
                else
                    sda_drive_low <= ~frm.out_bit;
            end
        end
    end

endmodule

//--- logic/eeprom_seq.sv
`timescale 1ns/1ps

module eeprom_seq (
    input  logic            CLK,
    input  logic            RESET,
    input  logic            wr,
    input  logic            rd,
    input  mem_pkg::addr_t  addr,
    input  i2c_pkg::byte_t  wdata,
    output i2c_pkg::byte_t  rdata,
    output logic            ack,
    output logic            ack_err,
    output logic            busy,
    bus_op_if.seq           bus
);
    import i2c_pkg::*;
    import mem_pkg::*;

    seq_state_t state;
    seq_state_t next_state;
    logic       go_r;
    logic       is_rd;
    logic       start_req;
    addr_t      addr_r;
    byte_t      wdata_r;
    block_t     blk;

    assign start_req = (state == s_idle) && (wr || rd);
    assign blk = addr_r[10:8];

    assign ack = (state == s_done);
    assign busy = (state != s_idle) && (state != s_done);

    assign bus.go = go_r;
    assign bus.master_nack = (state == s_data_r);  // single byte read ends with NACK

    always_comb
    begin
        bus.op = op_write;
        bus.tx_byte = addr_r[7:0];
        case (state)
            s_start:
            begin
                bus.op = op_start;
                next_state = s_ctrl_w;
            end
            s_ctrl_w:
            begin
                bus.tx_byte = {DEV_CODE, blk, 1'b0};
                next_state = s_addr;
            end
            s_addr:
                next_state = is_rd ? s_restart : s_data_w;
            s_data_w:
            begin
                bus.tx_byte = wdata_r;
                next_state = s_stop;
            end
            s_restart:
            begin
                bus.op = op_start;
                next_state = s_ctrl_r;
            end
            s_ctrl_r:
            begin
                bus.tx_byte = {DEV_CODE, blk, 1'b1};
                next_state = s_data_r;
            end
            s_data_r:
            begin
                bus.op = op_read;
                next_state = s_stop;
            end
            s_stop:
            begin
                bus.op = op_stop;
                next_state = s_done;
            end
            default:
                next_state = state;
        endcase
        // abort at the first missing acknowledge
        if ((bus.op == op_write) && bus.slave_nack)
            next_state = s_stop;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= s_idle;
            go_r <= 1'b0;
            is_rd <= 1'b0;
            ack_err <= 1'b0;
            rdata <= '0;
        end
        else
        begin
            go_r <= 1'b0;
            case (state)
                s_idle:
                    if (start_req)
                    begin
                        state <= s_start;
                        go_r <= 1'b1;
                        is_rd <= !wr;  // write wins
                        ack_err <= 1'b0;
                    end
                s_done:
                    state <= s_idle;
                default:
                    if (bus.done)
                    begin
                        state <= next_state;
                        go_r <= (next_state != s_done);
                        if ((bus.op == op_write) && bus.slave_nack)
                            ack_err <= 1'b1;
                        if (state == s_data_r)
                            rdata <= bus.rx_byte;
                    end
            endcase
        end
    end

    // request payload
    always_ff @(posedge CLK)
    begin
        if (start_req)
        begin
            addr_r <= addr;
            wdata_r <= wdata;
        end
    end

endmodule

//--- logic/eeprom_host.sv
`timescale 1ns/1ps

module eeprom_host (
    input  logic            CLK,
    input  logic            RESET,
    input  logic            wr,
    input  logic            rd,
    input  mem_pkg::addr_t  addr,
    input  i2c_pkg::byte_t  wdata,
    output i2c_pkg::byte_t  rdata,
    output logic            ack,
    output logic            ack_err,
    output logic            busy,
    output logic            scl,
    output logic            sda_drive_low,  // to open-drain pad
    input  logic            sda_in
);

    bus_op_if bus_op ();
    frame_if  frame ();

    eeprom_seq seq0 (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wdata   (wdata),
        .rdata   (rdata),
        .ack     (ack),
        .ack_err (ack_err),
        .busy    (busy),
        .bus     (bus_op.seq)
    );

    bit_engine engine0 (
        .CLK           (CLK),
        .RESET         (RESET),
        .bus           (bus_op.engine),
        .frm           (frame.engine),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

    frame_shifter shifter0 (
        .CLK   (CLK),
        .RESET (RESET),
        .frm   (frame.shifter)
    );

endmodule

//--- testbench/eeprom_slave.sv
`timescale 1ns/1ps

module eeprom_slave #(
    parameter mem_pkg::block_t ABSENT_BLOCK = 3'd7
) (
    input  logic clk,
    input  logic rst,
    input  logic scl,
    input  logic sda,       // resolved line level
    output logic sda_pull   // pulls the line low
);
    import i2c_pkg::*;
    import mem_pkg::*;

    typedef enum logic [1:0] {
        m_idle,
        m_rx,
        m_tx
    } mode_t;

    byte_t      mem [0:2047];
    mode_t      mode;
    logic       scl_p;
    logic       sda_p;
    logic [3:0] bit_cnt;
    byte_t      sr;
    logic [1:0] byte_idx;  // control, word address, data
    logic       reading;
    addr_t      ptr;

    // bus sampled with the system clock, edges found against the last sample
    always @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 2048; i++)
                mem[i] <= 8'hff;  // erased
            mode <= m_idle;
            scl_p <= 1'b1;
            sda_p <= 1'b1;
            bit_cnt <= '0;
            sr <= '0;
            byte_idx <= '0;
            reading <= 1'b0;
            ptr <= '0;
            sda_pull <= 1'b0;
        end
        else
        begin
            scl_p <= scl;
            sda_p <= sda;
            if (scl_p && scl && sda_p && !sda)
            begin
                mode <= m_rx;  // start or repeated start
                bit_cnt <= '0;
                byte_idx <= '0;
                sda_pull <= 1'b0;
            end
            else if (scl_p && scl && !sda_p && sda)
            begin
                mode <= m_idle;  // stop
                sda_pull <= 1'b0;
            end
            else if (!scl_p && scl)
            begin
                if ((mode == m_rx) && (bit_cnt < 4'd8))
                begin
                    sr <= {sr[6:0], sda};
                    bit_cnt <= bit_cnt + 1'b1;
                end
                else if (mode == m_tx)
                begin
                    if (bit_cnt == 4'd8)
                        mode <= m_idle;  // single byte read, wait for stop
                    else
                        bit_cnt <= bit_cnt + 1'b1;
                end
            end
            else if (scl_p && !scl)
            begin
                if ((mode == m_rx) && (bit_cnt == 4'd8))
                begin
                    bit_cnt <= 4'd9;
                    case (byte_idx)
                        2'd0:
                            if ((sr[7:4] == DEV_CODE) && (sr[3:1] != ABSENT_BLOCK))
                            begin
                                sda_pull <= 1'b1;
                                reading <= sr[0];
                                ptr[10:8] <= sr[3:1];
                                byte_idx <= 2'd1;
                            end
                            else
                                mode <= m_idle;  // no answer, line stays high
                        2'd1:
                        begin
                            sda_pull <= 1'b1;
                            ptr[7:0] <= sr;
                            byte_idx <= 2'd2;
                        end
                        default:
                        begin
                            sda_pull <= 1'b1;
                            mem[ptr] <= sr;
                        end
                    endcase
                end
                else if ((mode == m_rx) && (bit_cnt == 4'd9))
                begin
                    bit_cnt <= '0;
                    sda_pull <= 1'b0;
                    if (reading)
                    begin
                        mode <= m_tx;
                        sr <= mem[ptr];
                        sda_pull <= ~mem[ptr][7];
                    end
                end
                else if (mode == m_tx)
                begin
                    sda_pull <= (bit_cnt < 4'd8) ? ~sr[6] : 1'b0;  // release for master ack
                    sr <= {sr[6:0], 1'b1};
                end
            end
        end
    end

endmodule

//--- testbench/eeprom_host_assert.sv
`timescale 1ns/1ps

module eeprom_host_assert (
    input logic                             CLK,
    input logic                             RESET,
    input logic                             scl,
    input logic                             sda_drive_low,
    input logic                             ack,
    input logic                             busy,
    input mem_pkg::seq_state_t              state,
    input logic [i2c_pkg::QUARTER_BITS-1:0] q
);
    import mem_pkg::*;

    // SDA may move under a high SCL only in q3 of a start or stop
    sda_under_scl_a: assert property (@(posedge CLK) disable iff (RESET)
        ($past(scl) && scl && (sda_drive_low != $past(sda_drive_low)))
        |-> ((state inside {s_start, s_restart, s_stop}) && (q == '1)))
        else $error("sda_drive_low changed while scl was high outside start or stop");

    ack_pulse_a: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack)
        else $error("ack lasted more than one cycle");

    busy_fall_a: assert property (@(posedge CLK) disable iff (RESET)
        $fell(busy) |-> ack)
        else $error("busy fell without ack");

endmodule

bind eeprom_host eeprom_host_assert asrt0 (
    .CLK           (CLK),
    .RESET         (RESET),
    .scl           (scl),
    .sda_drive_low (sda_drive_low),
    .ack           (ack),
    .busy          (busy),
    .state         (seq0.state),
    .q             (engine0.q)
);

//--- testbench/tb_eeprom_host.sv
`timescale 1ns/1ps

module tb_eeprom_host;
    import i2c_pkg::*;
    import mem_pkg::*;

    localparam int SEED = 34;
    localparam int NUM_RANDOM = 40;
    localparam int NUM_DIRECTED = 10;
    localparam int CYCLES_PER_REQ = 200;  // a read needs about 170
    localparam int RESET_CYCLES = 3;
    localparam int IDLE_CYCLES = 6;
    localparam int LIMIT = (NUM_RANDOM + NUM_DIRECTED) * CYCLES_PER_REQ
                           + RESET_CYCLES + IDLE_CYCLES + 40;
    localparam block_t ABSENT_BLOCK = 3'd7;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    addr_t       addr;
    byte_t       wdata;
    byte_t       rdata;
    logic        ack;
    logic        ack_err;
    logic        busy;
    logic        scl;
    logic        sda_drive_low;
    logic        sda_in;
    logic        slave_pull;

    byte_t       shadow [0:2047];
    logic [9:0]  expected [$];  // {check rdata, ack_err, rdata}
    logic [31:0] rng;
    int          value_errors;
    int          protocol_errors;
    int          requests;
    int          acks;
    int          cycles;

    // wired-AND of the two open-drain drivers
    assign sda_in = !(sda_drive_low || slave_pull);

    eeprom_host dut0 (
        .CLK           (CLK),
        .RESET         (RESET),
        .wr            (wr),
        .rd            (rd),
        .addr          (addr),
        .wdata         (wdata),
        .rdata         (rdata),
        .ack           (ack),
        .ack_err       (ack_err),
        .busy          (busy),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

    eeprom_slave #(.ABSENT_BLOCK(ABSENT_BLOCK)) slave0 (
        .clk      (CLK),
        .rst      (RESET),
        .scl      (scl),
        .sda      (sda_in),
        .sda_pull (slave_pull)
    );

    always #2 CLK = ~CLK;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // {ack_err, rdata} a read of this address should return
    function automatic logic [8:0] expect_rd(input addr_t a);
        if (a[10:8] == ABSENT_BLOCK)
            return {1'b1, 8'h00};
        return {1'b0, shadow[a]};
    endfunction

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] want);
        if (got !== want)
        begin
            value_errors++;
            $display("error: %s got %h expected %h", name, got, want);
        end
    endtask

    task automatic send_request(input logic do_wr, input logic do_rd, input addr_t a,
                                input byte_t d);
        logic [8:0] exp;
        exp = expect_rd(a);
        @(negedge CLK);
        wr = do_wr;
        rd = do_rd;
        addr = a;
        wdata = d;
        if (do_wr)
        begin
            expected.push_back({1'b0, exp[8], 8'h00});
            if (!exp[8])
                shadow[a] = d;
        end
        else
            expected.push_back({!exp[8], exp[8], exp[7:0]});
        requests++;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        check_value("busy", {7'd0, busy}, 8'h01);
    endtask

    task automatic wait_for_ack();
        while (acks < requests)
            @(negedge CLK);
    endtask

    task automatic finish_run();
        $display("value errors %0d, protocol errors %0d, requests %0d, acks %0d",
                 value_errors, protocol_errors, requests, acks);
        if ((value_errors == 0) && (protocol_errors == 0))
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    endtask

    always @(posedge CLK)
    begin : compare_ack
        logic [9:0] exp;
        if (!RESET && ack)
        begin
            acks++;
            if (expected.size() == 0)
            begin
                protocol_errors++;
                $display("ack arrived with no request pending");
            end
            else
            begin
                exp = expected.pop_front();
                check_value("ack_err", {7'd0, ack_err}, {7'd0, exp[8]});
                if (exp[9])
                    check_value("rdata", rdata, exp[7:0]);
            end
        end
    end

    always @(posedge CLK)
    begin
        cycles++;
        if (cycles >= LIMIT)
        begin
            protocol_errors++;
            $display("timeout, the run did not finish within %0d cycles", LIMIT);
            finish_run();
        end
    end

    initial
    begin
        block_t blk;
        CLK = 1'b0;
        RESET = 1'b1;
        wr = 1'b0;
        rd = 1'b0;
        addr = '0;
        wdata = '0;
        rng = SEED;
        value_errors = 0;
        protocol_errors = 0;
        requests = 0;
        acks = 0;
        cycles = 0;
        for (int i = 0; i < 2048; i++)
            shadow[i] = 8'hff;  // erased
        repeat (RESET_CYCLES) @(negedge CLK);
        RESET = 1'b0;

        repeat (IDLE_CYCLES)
        begin
            @(negedge CLK);
            check_value("scl", {7'd0, scl}, 8'h01);
            check_value("sda_drive_low", {7'd0, sda_drive_low}, 8'h00);
            check_value("busy", {7'd0, busy}, 8'h00);
            check_value("ack", {7'd0, ack}, 8'h00);
            check_value("rdata", rdata, 8'h00);
        end

        send_request(1'b1, 1'b0, 11'h123, 8'h5a);
        wait_for_ack();
        send_request(1'b0, 1'b1, 11'h123, 8'h00);
        wait_for_ack();

        // absent block, then the same offset in block 1
        send_request(1'b1, 1'b0, {ABSENT_BLOCK, 8'h23}, 8'h99);
        wait_for_ack();
        send_request(1'b0, 1'b1, {ABSENT_BLOCK, 8'h23}, 8'h00);
        wait_for_ack();
        send_request(1'b0, 1'b1, 11'h123, 8'h00);
        wait_for_ack();

        // strobes while busy must be dropped
        send_request(1'b1, 1'b0, 11'h045, 8'hc3);
        repeat (10) @(negedge CLK);
        wr = 1'b1;
        addr = 11'h046;
        wdata = 8'h3c;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b1;
        @(negedge CLK);
        rd = 1'b0;
        wait_for_ack();
        send_request(1'b0, 1'b1, 11'h046, 8'h00);
        wait_for_ack();

        send_request(1'b1, 1'b1, 11'h310, 8'ha7);  // write wins
        wait_for_ack();
        send_request(1'b0, 1'b1, 11'h310, 8'h00);
        wait_for_ack();

        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            rng = xorshift(rng);
            blk = block_t'(rng[15:8] % 8'd7);
            send_request(rng[0], !rng[0], {blk, 4'h0, rng[19:16]}, rng[31:24]);
            wait_for_ack();
        end

        repeat (20) @(negedge CLK);
        if ((expected.size() != 0) || (acks != requests))
        begin
            protocol_errors++;
            $display("ack count does not match the accepted requests");
        end
        finish_run();
    end

endmodule

//--- list.f
logic/i2c_pkg.sv
logic/mem_pkg.sv
logic/bus_op_if.sv
logic/frame_if.sv
logic/frame_shifter.sv
logic/bit_engine.sv
logic/eeprom_seq.sv
logic/eeprom_host.sv
testbench/eeprom_slave.sv
testbench/eeprom_host_assert.sv
testbench/tb_eeprom_host.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_eeprom_host
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= Simulation PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
